//--- address_translator.sv
module address_translator import bus_pkg::*; (
    input  bus_data_t virtual_addr,
    output bus_data_t phys_addr,
    output dev_vec_t  device_en
);

    logic [DEV_SEL_WIDTH-1:0] dev_field;

    assign dev_field = virtual_addr[DEV_SEL_LSB +: DEV_SEL_WIDTH];

    // One-hot slave select from the device field
    always_comb begin
        device_en = dev_vec_t'(1) << dev_field;
    end

    // Each slave sees its own space starting at zero
    always_comb begin
        phys_addr = virtual_addr;
        phys_addr[DEV_SEL_LSB +: DEV_SEL_WIDTH] = '0;
    end

endmodule

//--- bus_controller.sv
module bus_controller import bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dev_vec_t  req,
    output dev_vec_t  ack,
    input  bus_ctrl_t ctrl_in [NUM_DEVICES],
    output bus_ctrl_t ctrl_out,
    input  bus_data_t bus_in [NUM_DEVICES],
    output bus_data_t bus_out
);

    logic     arb_enable;
    logic     is_write;
    logic     initiator_req;
    dev_vec_t grant;

    bus_path_if u_path ();

    priority_arbiter u_arbiter (
        .clk    (clk),
        .rst    (rst),
        .enable (arb_enable),
        .req    (req),
        .grant  (grant)
    );

    bus_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .initiator_req (initiator_req),
        .is_write      (is_write),
        .arb_enable    (arb_enable),
        .path          (u_path.sequencer)
    );

    bus_datapath u_datapath (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .grant         (grant),
        .ctrl_in       (ctrl_in),
        .bus_in        (bus_in),
        .path          (u_path.datapath),
        .ack           (ack),
        .ctrl_out      (ctrl_out),
        .bus_out       (bus_out),
        .is_write      (is_write),
        .initiator_req (initiator_req)
    );

endmodule

//--- bus_datapath.sv
module bus_datapath import bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  dev_vec_t    req,
    input  dev_vec_t    grant,
    input  bus_ctrl_t   ctrl_in [NUM_DEVICES],
    input  bus_data_t   bus_in [NUM_DEVICES],
    bus_path_if.datapath path,
    output dev_vec_t    ack,
    output bus_ctrl_t   ctrl_out,
    output bus_data_t   bus_out,
    output logic        is_write,
    output logic        initiator_req
);

    dev_vec_t                initiator_q;
    dev_vec_t                slave_q;
    dev_vec_t                owner_sel;
    dev_vec_t                device_en;
    logic                    we_q;
    logic [BURST_WIDTH-1:0]  burst_q;
    bus_data_t               prev_bus;
    bus_data_t               master_data;
    bus_data_t               owner_data;
    bus_data_t               phys_addr;
    bus_ctrl_t               sel_ctrl;
    bus_ctrl_t               forced_ctrl;

    bus_select_mux #(.payload_t(bus_data_t)) u_master_data_mux (
        .sel (grant),
        .in  (bus_in),
        .out (master_data)
    );

    address_translator u_translator (
        .virtual_addr (master_data),
        .phys_addr    (phys_addr),
        .device_en    (device_en)
    );

    // Write data comes from the initiator, read data from the slave
    assign owner_sel = (path.owner == OWNER_MASTER) ? initiator_q : slave_q;

    bus_select_mux #(.payload_t(bus_data_t)) u_owner_data_mux (
        .sel (owner_sel),
        .in  (bus_in),
        .out (owner_data)
    );

    bus_select_mux #(.payload_t(bus_ctrl_t)) u_ctrl_mux (
        .sel (ack),
        .in  (ctrl_in),
        .out (sel_ctrl)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            initiator_q <= '0;
            slave_q     <= '0;
            we_q        <= 1'b0;
        end else begin
            if (path.capture_master) begin
                initiator_q <= grant;
                we_q        <= sel_ctrl[CTRL_WE_BIT];
            end
            if (path.clear_slave) begin
                slave_q <= '0;
            end else if (path.capture_slave) begin
                slave_q <= device_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (path.capture_master) begin
            burst_q <= sel_ctrl[CTRL_BURST_LSB +: BURST_WIDTH];
        end
        prev_bus <= bus_out;
    end

    always_comb begin
        case (path.state)
            IDLE:      ack = '0;
            ACK, ADDR: ack = grant;
            default:   ack = slave_q;
        endcase
    end

    always_comb begin
        forced_ctrl = '0;
        forced_ctrl[CTRL_WAIT_BIT] = 1'b1;
        forced_ctrl[CTRL_WE_BIT] = we_q;
        forced_ctrl[CTRL_BURST_LSB +: BURST_WIDTH] = burst_q;
    end

    assign ctrl_out = path.force_ctrl ? forced_ctrl : sel_ctrl;

    assign bus_out = path.hold_addr  ? prev_bus  :
                     path.addr_phase ? phys_addr : owner_data;

    assign is_write      = we_q;
    assign initiator_req = |(req & initiator_q);

    // Arbiter grant and decoded slave must name exactly one device
    a_ack_onehot: assert property (
        @(posedge clk) disable iff (rst)
        (path.state != IDLE) |-> $onehot(ack)
    ) else $error("ack not one-hot outside IDLE: %b", ack);

endmodule

//--- bus_path_if.sv
interface bus_path_if import bus_pkg::*; ();

    bus_state_t state;
    bus_owner_t owner;
    logic       capture_master;
    logic       capture_slave;
    logic       clear_slave;
    logic       hold_addr;
    logic       force_ctrl;
    logic       addr_phase;

    modport sequencer (
        output state,
        output owner,
        output capture_master,
        output capture_slave,
        output clear_slave,
        output hold_addr,
        output force_ctrl,
        output addr_phase
    );

    modport datapath (
        input state,
        input owner,
        input capture_master,
        input capture_slave,
        input clear_slave,
        input hold_addr,
        input force_ctrl,
        input addr_phase
    );

endinterface

//--- bus_pkg.sv
package bus_pkg;

    // Bus geometry
    localparam int NUM_DEVICES = 8;
    localparam int BUS_WIDTH   = 32;
    localparam int CTRL_WIDTH  = 8;

    // Address map: the top three address bits pick the device
    localparam int DEV_SEL_WIDTH = 3;
    localparam int DEV_SEL_LSB   = 29;

    // Control word layout, bits 7..5 are reserved and zero
    localparam int CTRL_WAIT_BIT  = 0;
    localparam int CTRL_WE_BIT    = 1;
    localparam int CTRL_BURST_LSB = 2;
    localparam int BURST_WIDTH    = 3;

    typedef logic [BUS_WIDTH-1:0]   bus_data_t;
    typedef logic [CTRL_WIDTH-1:0]  bus_ctrl_t;
    typedef logic [NUM_DEVICES-1:0] dev_vec_t;

    // Transfer phases
    typedef enum logic [2:0] {
        IDLE,
        ACK,
        ADDR,
        ACK_SLAVE,
        BUSY,
        FINISH
    } bus_state_t;

    // Side that drives bus data during the data phase
    typedef enum logic {
        OWNER_MASTER,
        OWNER_SLAVE
    } bus_owner_t;

endpackage

//--- bus_select_mux.sv
module bus_select_mux import bus_pkg::*; #(
    parameter type payload_t = bus_data_t
) (
    input  dev_vec_t sel,
    input  payload_t in [NUM_DEVICES],
    output payload_t out
);

    // AND-OR select, no selected device gives zero
    always_comb begin
        out = '0;
        for (int i = 0; i < NUM_DEVICES; i++) begin
            if (sel[i]) begin
                out = out | in[i];
            end
        end
    end

    // Overlapping selects would OR two payloads together
    always_comb begin
        a_sel_onehot0: assert final ($onehot0(sel))
            else $error("mux select is not one-hot: %b", sel);
    end

endmodule

//--- bus_sequencer.sv
module bus_sequencer import bus_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  dev_vec_t           req,
    input  logic               initiator_req,
    input  logic               is_write,
    output logic               arb_enable,
    bus_path_if.sequencer      path
);

    bus_state_t state;
    bus_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (req != '0) begin
                    next_state = ACK;
                end
            end
            ACK: begin
                next_state = ADDR;
            end
            ADDR: begin
                next_state = ACK_SLAVE;
            end
            ACK_SLAVE: begin
                next_state = BUSY;
            end
            BUSY: begin
                // Only the initiator's own request keeps the bus
                if (!initiator_req) begin
                    next_state = FINISH;
                end
            end
            FINISH: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Path strobes per state
    always_comb begin
        arb_enable          = 1'b0;
        path.owner          = OWNER_MASTER;
        path.capture_master = 1'b0;
        path.capture_slave  = 1'b0;
        path.clear_slave    = 1'b0;
        path.hold_addr      = 1'b0;
        path.force_ctrl     = 1'b0;
        path.addr_phase     = 1'b0;
        case (state)
            IDLE: begin
                arb_enable = 1'b1;
            end
            ACK: begin
                path.addr_phase     = 1'b1;
                path.capture_master = 1'b1;
            end
            ADDR: begin
                path.addr_phase    = 1'b1;
                path.capture_slave = 1'b1;
            end
            ACK_SLAVE: begin
                // Slave gets one more look at the address, wait raised
                path.hold_addr  = 1'b1;
                path.force_ctrl = 1'b1;
            end
            BUSY: begin
                path.owner = is_write ? OWNER_MASTER : OWNER_SLAVE;
            end
            FINISH: begin
                path.owner       = is_write ? OWNER_MASTER : OWNER_SLAVE;
                path.clear_slave = 1'b1;
                arb_enable       = 1'b1;
            end
            default: begin
                arb_enable = 1'b1;
            end
        endcase
    end

    assign path.state = state;

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {IDLE, ACK, ADDR, ACK_SLAVE, BUSY, FINISH}
    ) else $error("sequencer state out of range: %0d", state);

    // Initiator and slave are latched in separate phases
    a_capture_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(path.capture_master && path.capture_slave)
    ) else $error("master and slave capture in the same cycle");

endmodule

//--- files.f
bus_pkg.sv
bus_path_if.sv
priority_arbiter.sv
address_translator.sv
bus_select_mux.sv
bus_sequencer.sv
bus_datapath.sv
bus_controller.sv
tb_bus_controller.sv

//--- priority_arbiter.sv
module priority_arbiter import bus_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     enable,
    input  dev_vec_t req,
    output dev_vec_t grant
);

    dev_vec_t lowest_req;

    // Two's complement trick isolates the lowest set bit, zero stays zero
    assign lowest_req = req & (~req + 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= '0;
        end else if (enable) begin
            grant <= lowest_req;
        end
    end

    // Grant may be idle but never names two masters
    a_grant_onehot0: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(grant)
    ) else $error("arbiter grant is not one-hot: %b", grant);

endmodule

//--- tb_bus_controller.sv
module tb_bus_controller import bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 40;
    localparam int NUM_TRANSFERS = 6;
    localparam int MARGIN_CYCLES = 20;

    typedef struct {
        dev_vec_t   req;
        bus_data_t  vaddr;
        logic       we;
        logic [2:0] burst;
        bus_data_t  master_data;
        bus_data_t  slave_data;
        bus_ctrl_t  slave_ctrl;
        int         busy_cycles;
    } transfer_t;

    logic      clk;
    logic      rst;
    dev_vec_t  req;
    dev_vec_t  ack;
    bus_ctrl_t ctrl_in [NUM_DEVICES];
    bus_ctrl_t ctrl_out;
    bus_data_t bus_in [NUM_DEVICES];
    bus_data_t bus_out;
    transfer_t transfers [NUM_TRANSFERS];
    bit        table_ready = 1'b0;

    bus_controller u_dut (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .ack      (ack),
        .ctrl_in  (ctrl_in),
        .ctrl_out (ctrl_out),
        .bus_in   (bus_in),
        .bus_out  (bus_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Distinct idle values per device
    function automatic bus_data_t fill_data(input int dev);
        return 32'hC0DE_0000 | (dev * 32'h0000_1111);
    endfunction

    function automatic bus_ctrl_t fill_ctrl(input int dev);
        return bus_ctrl_t'(8'h80 | (dev << 2) | 1);
    endfunction

    function automatic int lowest_requester(input dev_vec_t r);
        int idx;
        idx = -1;
        for (int i = NUM_DEVICES - 1; i >= 0; i--) begin
            if (r[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic longint watchdog_limit();
        longint total;
        total = MARGIN_CYCLES;
        for (int t = 0; t < NUM_TRANSFERS; t++) begin
            total += transfers[t].busy_cycles + 6;
        end
        return total * CLK_PERIOD;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("MISMATCH time=%0t signal=%s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic check_idle();
        compare_value("ack", ack, '0);
        compare_value("ctrl_out", ctrl_out, '0);
    endtask

    task automatic check_outputs(input dev_vec_t exp_ack, input bus_data_t exp_bus,
                                 input bus_ctrl_t exp_ctrl);
        compare_value("ack", ack, exp_ack);
        compare_value("bus_out", bus_out, exp_bus);
        compare_value("ctrl_out", ctrl_out, exp_ctrl);
    endtask

    // Each row holds req, virtual address, we, burst, master data, slave data,
    // slave ctrl and the number of BUSY cycles
    task automatic load_table();
        transfers[0] = '{8'b0000_0100, {3'd5, 29'h0123_4567}, 1'b1, 3'd3, 0, 0, 8'h5A, 3};
        transfers[1] = '{8'b1010_1000, {3'd0, 29'h1ABC_DEF0}, 1'b0, 3'd5, 0, 0, 8'hC3, 4};
        transfers[2] = '{8'b1111_1111, {3'd7, 29'h0000_0040}, 1'b1, 3'd7, 0, 0, 8'h3C, 1};
        transfers[3] = '{8'b1000_0000, {3'd1, 29'h1FFF_FFFC}, 1'b0, 3'd0, 0, 0, 8'h01, 2};
        transfers[4] = '{8'b0110_0000, {3'd6, 29'h0555_AAA8}, 1'b0, 3'd2, 0, 0, 8'hE7, 5};
        transfers[5] = '{8'b0000_0010, {3'd4, 29'h1234_5678}, 1'b1, 3'd6, 0, 0, 8'h96, 1};
        for (int t = 0; t < NUM_TRANSFERS; t++) begin
            transfers[t].master_data = $urandom;
            transfers[t].slave_data  = $urandom;
        end
    endtask

    task automatic run_transfer(input transfer_t tr);
        int        m;
        int        s;
        dev_vec_t  m_vec;
        dev_vec_t  s_vec;
        bus_data_t phys;
        bus_ctrl_t m_ctrl;
        bus_ctrl_t wait_ctrl;
        bus_data_t mdata;
        bus_data_t sdata;
        m         = lowest_requester(tr.req);
        s         = int'(tr.vaddr[DEV_SEL_LSB +: 3]);
        m_vec     = dev_vec_t'(1) << m;
        s_vec     = dev_vec_t'(1) << s;
        phys      = {3'b000, tr.vaddr[28:0]};
        m_ctrl    = {3'b000, tr.burst, tr.we, 1'b0};
        wait_ctrl = {3'b000, tr.burst, tr.we, 1'b1};
        mdata     = tr.master_data;
        sdata     = tr.slave_data;

        // Requests go up while the controller still sits in IDLE
        @(posedge clk);
        req        <= tr.req;
        bus_in[m]  <= tr.vaddr;
        ctrl_in[m] <= m_ctrl;
        @(negedge clk);
        check_idle();

        // ACK then ADDR
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_outputs(m_vec, phys, m_ctrl);
        end

        // ACK_SLAVE keeps the address although the master already shows its data
        @(posedge clk);
        bus_in[m]  <= mdata;
        bus_in[s]  <= sdata;
        ctrl_in[s] <= tr.slave_ctrl;
        @(negedge clk);
        check_outputs(s_vec, phys, wait_ctrl);

        // Fresh data every BUSY cycle
        // The initiator drops its request in the last one
        for (int k = 0; k < tr.busy_cycles; k++) begin
            @(posedge clk);
            mdata     = tr.master_data + k;
            sdata     = tr.slave_data ^ k;
            bus_in[m] <= mdata;
            bus_in[s] <= sdata;
            if (k == tr.busy_cycles - 1) begin
                req <= tr.req & ~m_vec;
            end
            @(negedge clk);
            check_outputs(s_vec, tr.we ? mdata : sdata, tr.slave_ctrl);
        end

        // FINISH looks like BUSY on the outputs
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        check_outputs(s_vec, tr.we ? mdata : sdata, tr.slave_ctrl);

        @(posedge clk);
        bus_in[m]  <= fill_data(m);
        bus_in[s]  <= fill_data(s);
        ctrl_in[m] <= fill_ctrl(m);
        ctrl_in[s] <= fill_ctrl(s);
        @(negedge clk);
        check_idle();
    endtask

    initial begin
        void'($urandom(60478));
        load_table();
        table_ready = 1'b1;

        rst = 1'b1;
        req = '0;
        for (int i = 0; i < NUM_DEVICES; i++) begin
            bus_in[i]  = fill_data(i);
            ctrl_in[i] = fill_ctrl(i);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Quiet bus right after reset
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end

        for (int t = 0; t < NUM_TRANSFERS; t++) begin
            run_transfer(transfers[t]);
        end

        $display("TEST PASS");
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = watchdog_limit();
        #(limit_ns);
        $display("ERROR: watchdog expired, the run did not finish within %0d ns", limit_ns);
        $display("TEST FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule
